// ==== cmd_sequencer.sv ====
`default_nettype none

// Command FSM for the four-phase req/ack port
// One command at a time, steers memory, ALU and timer
module cmd_sequencer (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    cmd_req,
  input  wire ctrl_pkg::cmd_op_t cmd_op,
  input  wire ctrl_pkg::inst_t   cmd_inst,
  output logic                   cmd_ack,
  output logic                   ld_we,
  output logic                   wb_we,
  output logic                   rd_ab,
  output logic                   rd_c,
  output mem_pkg::addr_t         rd_addr_a,
  output mem_pkg::addr_t         rd_addr_b,
  output mem_pkg::addr_t         wb_addr,
  output ctrl_pkg::alu_op_t      alu_op,
  output logic                   tmr_load,
  output ctrl_pkg::tmr_t         tmr_count,
  input  wire                    tmr_done,
  output logic                   rsp_sel,   // 1 picks port c
  output logic                   rsp_load
);

  ctrl_pkg::seq_state_t state;
  ctrl_pkg::seq_state_t state_nxt;
  ctrl_pkg::cmd_op_t    op_q;  // Command in flight

  ////////////////////////////////////////////////////////////////////////////
  // State register and command capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ctrl_pkg::IDLE;
      op_q  <= ctrl_pkg::LOAD;
    end else begin
      state <= state_nxt;
      if (state == ctrl_pkg::IDLE && cmd_req) begin
        op_q <= cmd_op;
      end
    end
  end

  // Opcode and dst held for the ALU and write-back
  always_ff @(posedge clk) begin
    if (state == ctrl_pkg::ISSUE) begin
      alu_op  <= ctrl_pkg::alu_op_t'(cmd_inst[25:24]);
      wb_addr <= cmd_inst[7:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    unique case (state)
      ctrl_pkg::IDLE: begin
        if (cmd_req) begin
          state_nxt = ctrl_pkg::ISSUE;
        end
      end
      ctrl_pkg::ISSUE: begin
        // LOAD needs no read
        state_nxt = (op_q == ctrl_pkg::LOAD) ? ctrl_pkg::ACK : ctrl_pkg::WAIT;
      end
      ctrl_pkg::WAIT: begin
        if (tmr_done) begin
          state_nxt = (op_q == ctrl_pkg::EXEC) ? ctrl_pkg::WRITE : ctrl_pkg::ACK;
        end
      end
      ctrl_pkg::WRITE: state_nxt = ctrl_pkg::ACK;
      ctrl_pkg::ACK: begin
        if (!cmd_req) begin
          state_nxt = ctrl_pkg::IDLE;  // Host released the request
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign rd_addr_a = cmd_inst[15:8];   // src1, PEEK address too
  assign rd_addr_b = cmd_inst[23:16];  // src2

  assign cmd_ack  = (state == ctrl_pkg::ACK);
  assign ld_we    = (state == ctrl_pkg::ISSUE) && (op_q == ctrl_pkg::LOAD);
  assign rd_ab    = (state == ctrl_pkg::ISSUE) &&
                    (op_q == ctrl_pkg::PEEK || op_q == ctrl_pkg::EXEC);
  assign rd_c     = (state == ctrl_pkg::ISSUE) && (op_q == ctrl_pkg::DUMP);
  assign tmr_load = (state == ctrl_pkg::ISSUE) && (op_q != ctrl_pkg::LOAD);
  assign wb_we    = (state == ctrl_pkg::WRITE);

  // EXEC waits one more cycle for the ALU register
  assign tmr_count = (op_q == ctrl_pkg::EXEC) ? ctrl_pkg::tmr_t'(mem_pkg::RD_LAT + 1)
                                              : ctrl_pkg::tmr_t'(mem_pkg::RD_LAT);

  assign rsp_load = (state == ctrl_pkg::WAIT) && tmr_done && (op_q != ctrl_pkg::EXEC);
  assign rsp_sel  = (op_q == ctrl_pkg::DUMP);

endmodule

`default_nettype wire

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Host commands
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    LOAD = 2'd0,  // Write at load pointer
    EXEC = 2'd1,  // Read, compute, write back
    PEEK = 2'd2,  // Read one word on port a
    DUMP = 2'd3   // Next word of result region
  } cmd_op_t;

  typedef enum logic [1:0] {
    ADD  = 2'd0,
    SUB  = 2'd1,  // src1 minus src2
    XOR  = 2'd2,
    PASS = 2'd3   // src1 unchanged
  } alu_op_t;

  // Opcode 25:24, src2 23:16, src1 15:8, dst 7:0
  typedef logic [25:0] inst_t;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {IDLE, ISSUE, WAIT, WRITE, ACK} seq_state_t;

  typedef logic [2:0] tmr_t;  // Latency count in cycles

endpackage

`default_nettype wire

// ==== data_mem.sv ====
`default_nettype none

// Three-read one-write data memory
// Built from three RAM copies that see the same writes
module data_mem #(
  parameter mem_pkg::addr_t Y_BASE = mem_pkg::Y_BASE_DEF  // Dump pointer start
) (
  input  wire                 clk,
  input  wire                 rst,
  // Write side
  input  wire                 ld_we,      // LOAD at load pointer
  input  wire                 wb_we,      // EXEC write-back
  input  wire mem_pkg::word_t ld_data,
  input  wire mem_pkg::word_t wb_data,
  input  wire mem_pkg::addr_t wb_addr,
  // Read side
  input  wire                 rd_ab,      // Ports a and b together
  input  wire mem_pkg::addr_t rd_addr_a,
  input  wire mem_pkg::addr_t rd_addr_b,
  input  wire                 rd_c,       // Port c at dump pointer
  output mem_pkg::word_t      douta,
  output mem_pkg::word_t      doutb,
  output mem_pkg::word_t      doutc
);

  mem_pkg::addr_t ld_ptr;    // Next LOAD address
  mem_pkg::addr_t dump_ptr;  // Next DUMP address
  mem_pkg::addr_t waddr;
  mem_pkg::word_t wdata;
  logic           we;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////////////////////////////////////////

  // Both wrap at 256 through the 8-bit type
  always_ff @(posedge clk) begin
    if (rst) begin
      ld_ptr   <= '0;
      dump_ptr <= Y_BASE;
    end else begin
      if (ld_we) begin
        ld_ptr <= ld_ptr + 1'b1;
      end
      if (rd_c) begin
        dump_ptr <= dump_ptr + 1'b1;  // Port c samples the old value
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Shared write port
  ////////////////////////////////////////////////////////////////////////////

  // LOAD and write-back never overlap, LOAD still wins
  assign we    = ld_we | wb_we;
  assign waddr = ld_we ? ld_ptr : wb_addr;
  assign wdata = ld_we ? ld_data : wb_data;

  ////////////////////////////////////////////////////////////////////////////
  // RAM copies
  ////////////////////////////////////////////////////////////////////////////

  sdp_bram bram_a (
    .clk   (clk),
    .rst   (rst),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .re    (rd_ab),
    .raddr (rd_addr_a),  // src1, also the PEEK address
    .rdata (douta)
  );

  sdp_bram bram_b (
    .clk   (clk),
    .rst   (rst),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .re    (rd_ab),
    .raddr (rd_addr_b),  // src2
    .rdata (doutb)
  );

  sdp_bram bram_c (
    .clk   (clk),
    .rst   (rst),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .re    (rd_c),
    .raddr (dump_ptr),
    .rdata (doutc)
  );

endmodule

`default_nettype wire

// ==== dm_core.sv ====
`default_nettype none

// Vector scratchpad top level
// Sequencer, timer, three-read memory, two-lane ALU, response register
module dm_core #(
  parameter mem_pkg::addr_t Y_BASE = mem_pkg::Y_BASE_DEF  // Result region base
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    cmd_req,
  input  wire ctrl_pkg::cmd_op_t cmd_op,
  input  wire ctrl_pkg::inst_t   cmd_inst,
  input  wire mem_pkg::word_t    cmd_wdata,
  output logic                   cmd_ack,
  output mem_pkg::word_t         rsp_data
);

  // Sequencer controls
  logic ld_we;
  logic wb_we;
  logic rd_ab;
  logic rd_c;
  logic rsp_sel;
  logic rsp_load;
  mem_pkg::addr_t    rd_addr_a;
  mem_pkg::addr_t    rd_addr_b;
  mem_pkg::addr_t    wb_addr;
  ctrl_pkg::alu_op_t alu_op;

  // Timer
  logic           tmr_load;
  logic           tmr_done;
  ctrl_pkg::tmr_t tmr_count;

  // Datapath
  mem_pkg::word_t douta;
  mem_pkg::word_t doutb;
  mem_pkg::word_t doutc;
  mem_pkg::word_t alu_y;

  cmd_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .cmd_req   (cmd_req),
    .cmd_op    (cmd_op),
    .cmd_inst  (cmd_inst),
    .cmd_ack   (cmd_ack),
    .ld_we     (ld_we),
    .wb_we     (wb_we),
    .rd_ab     (rd_ab),
    .rd_c      (rd_c),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .wb_addr   (wb_addr),
    .alu_op    (alu_op),
    .tmr_load  (tmr_load),
    .tmr_count (tmr_count),
    .tmr_done  (tmr_done),
    .rsp_sel   (rsp_sel),
    .rsp_load  (rsp_load)
  );

  latency_timer u_tmr (
    .clk   (clk),
    .rst   (rst),
    .load  (tmr_load),
    .count (tmr_count),
    .done  (tmr_done)
  );

  data_mem #(
    .Y_BASE (Y_BASE)
  ) u_mem (
    .clk       (clk),
    .rst       (rst),
    .ld_we     (ld_we),
    .wb_we     (wb_we),
    .ld_data   (cmd_wdata),
    .wb_data   (alu_y),     // Write-back straight from the ALU register
    .wb_addr   (wb_addr),
    .rd_ab     (rd_ab),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_c      (rd_c),
    .douta     (douta),
    .doutb     (doutb),
    .doutc     (doutc)
  );

  lane_alu u_alu (
    .clk (clk),
    .rst (rst),
    .op  (alu_op),
    .a   (douta),
    .b   (doutb),
    .y   (alu_y)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response register, stable while cmd_ack is high
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_data <= '0;
    end else if (rsp_load) begin
      rsp_data <= rsp_sel ? doutc : douta;  // DUMP or PEEK
    end
  end

endmodule

`default_nettype wire

// ==== dm_core_assert.sv ====
`default_nettype none

// Command port checks inside dm_core
module dm_core_assert (
  input wire clk,
  input wire rst,
  input wire cmd_req,
  input wire cmd_ack,
  input wire ld_we,
  input wire wb_we
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned err_cnt = 0;  // Assertion failures so far

  // Ack only answers a live request
  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(cmd_ack) |-> cmd_req)
    else begin
      $error("cmd_ack rose while cmd_req was low");
      err_cnt++;
    end

  // Back-pressure, ack held until the host lets go
  ack_held: assert property (@(posedge clk) disable iff (rst)
    (cmd_ack && cmd_req) |=> cmd_ack)
    else begin
      $error("cmd_ack dropped while cmd_req was still high");
      err_cnt++;
    end

  // Shared write port
  one_writer: assert property (@(posedge clk) disable iff (rst) !(ld_we && wb_we))
    else begin
      $error("ld_we and wb_we high in the same cycle");
      err_cnt++;
    end

endmodule

bind dm_core dm_core_assert u_assert (
  .clk     (clk),
  .rst     (rst),
  .cmd_req (cmd_req),
  .cmd_ack (cmd_ack),
  .ld_we   (ld_we),
  .wb_we   (wb_we)
);

`default_nettype wire

// ==== flist.f ====
mem_pkg.sv
ctrl_pkg.sv
sdp_bram.sv
latency_timer.sv
lane_alu.sv
data_mem.sv
cmd_sequencer.sv
dm_core.sv
dm_core_assert.sv
tb_dm_core.sv

// ==== lane_alu.sv ====
`default_nettype none

// Two-lane ALU with a registered result
// Lanes never carry into each other
module lane_alu (
  input  wire                    clk,
  input  wire                    rst,
  input  wire ctrl_pkg::alu_op_t op,
  input  wire mem_pkg::word_t    a,   // src1
  input  wire mem_pkg::word_t    b,   // src2
  output mem_pkg::word_t         y
);

  localparam int LW = mem_pkg::LANE_W;

  mem_pkg::word_t y_next;

  always_comb begin : lane_calc
    mem_pkg::lane_t la;
    mem_pkg::lane_t lb;
    mem_pkg::lane_t ly;
    y_next = '0;
    for (int i = 0; i < mem_pkg::LANES; i++) begin
      la = a[i*LW +: LW];
      lb = b[i*LW +: LW];
      unique case (op)
        ctrl_pkg::ADD:  ly = la + lb;  // Wraps mod 2^16
        ctrl_pkg::SUB:  ly = la - lb;
        ctrl_pkg::XOR:  ly = la ^ lb;
        ctrl_pkg::PASS: ly = la;
      endcase
      y_next[i*LW +: LW] = ly;
    end
  end

  // One cycle of latency
  always_ff @(posedge clk) begin
    if (rst) begin
      y <= '0;
    end else begin
      y <= y_next;
    end
  end

endmodule

`default_nettype wire

// ==== latency_timer.sv ====
`default_nettype none

// Down-counter for RAM and ALU latency
// done is high in the cycle count cycles after load, count of 1 or more
module latency_timer (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 load,
  input  wire ctrl_pkg::tmr_t count,
  output logic                done
);

  ctrl_pkg::tmr_t cnt;
  logic           busy;  // Low when idle, keeps done quiet

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= '0;
      busy <= 1'b0;
    end else if (load) begin
      cnt  <= count - 1'b1;  // Load cycle counts as the first
      busy <= 1'b1;
    end else if (busy) begin
      if (cnt == '0) begin
        busy <= 1'b0;  // Single pulse
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  assign done = busy && (cnt == '0);

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Word and lane layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int LANE_W = 16;          // One lane
  localparam int LANES  = 2;           // Lanes per word
  localparam int WORD_W = LANES * LANE_W;

  // Lane 0 sits in the low half of the word
  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [WORD_W-1:0] word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Address space
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 8;           // 256 words
  localparam int DEPTH  = 2 ** ADDR_W; // Entries per RAM copy

  typedef logic [ADDR_W-1:0] addr_t;

  // Start of the result region read back by DUMP
  localparam addr_t Y_BASE_DEF = 8'h20;

  ////////////////////////////////////////////////////////////////////////////
  // RAM timing
  ////////////////////////////////////////////////////////////////////////////

  // Read stage plus output register, like a BRAM in high-performance mode
  localparam int RD_LAT = 2;

endpackage

`default_nettype wire

// ==== sdp_bram.sv ====
`default_nettype none

// Simple dual-port RAM, one clock, write port and read port
// Read data shows up RD_LAT cycles after re and raddr are sampled
module sdp_bram (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 we,
  input  wire mem_pkg::addr_t waddr,
  input  wire mem_pkg::word_t wdata,
  input  wire                 re,
  input  wire mem_pkg::addr_t raddr,
  output mem_pkg::word_t      rdata
);

  localparam int OUT_STAGES = mem_pkg::RD_LAT - 1;  // Stages after the read

  mem_pkg::word_t mem [mem_pkg::DEPTH];
  mem_pkg::word_t rd_q;                // Array read stage
  mem_pkg::word_t out_q [OUT_STAGES];  // Output register chain

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read stage holds its word while re is low
  always_ff @(posedge clk) begin
    if (re) begin
      rd_q <= mem[raddr];  // Read-first on address clash
    end
  end

  // Output registers, the only part that rst touches
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < OUT_STAGES; i++) begin
        out_q[i] <= '0;
      end
    end else begin
      out_q[0] <= rd_q;
      for (int i = 1; i < OUT_STAGES; i++) begin
        out_q[i] <= out_q[i-1];
      end
    end
  end

  assign rdata = out_q[OUT_STAGES-1];

endmodule

`default_nettype wire

// ==== tb_dm_core.sv ====
`default_nettype none

// Directed testbench for dm_core
// Reference memory model and one task per host command
module tb_dm_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int             CLK_PERIOD  = 40;
  localparam int             RST_CYCLES  = 16;
  localparam int             ACK_TIMEOUT = 64;  // Cycles per handshake phase
  localparam int unsigned    SEED        = 32'ha56b7c8e;
  localparam mem_pkg::addr_t Y_BASE      = 8'h20;
  localparam int             N_LOAD      = 48;

  logic              clk;
  logic              rst;
  logic              cmd_req;
  ctrl_pkg::cmd_op_t cmd_op;
  ctrl_pkg::inst_t   cmd_inst;
  mem_pkg::word_t    cmd_wdata;
  logic              cmd_ack;
  mem_pkg::word_t    rsp_data;

  // Model state
  mem_pkg::word_t ref_mem [256];
  mem_pkg::addr_t ld_ptr_m;
  mem_pkg::addr_t dump_ptr_m;

  dm_core #(.Y_BASE(Y_BASE)) UUT (
    .clk       (clk),
    .rst       (rst),
    .cmd_req   (cmd_req),
    .cmd_op    (cmd_op),
    .cmd_inst  (cmd_inst),
    .cmd_wdata (cmd_wdata),
    .cmd_ack   (cmd_ack),
    .rsp_data  (rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string test, input mem_pkg::word_t exp,
                            input mem_pkg::word_t act);
    if (act !== exp) begin
      fail_run($sformatf("** Error %s: expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic check_ack(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("** Error %s: expected ack %b, actual ack %b", test, exp, act));
    end
  endtask

  // Lane rule with lane 0 in the low half and no carry between lanes
  function automatic mem_pkg::word_t lane_result(input ctrl_pkg::alu_op_t op,
                                                 input mem_pkg::word_t src1,
                                                 input mem_pkg::word_t src2);
    mem_pkg::lane_t r_lo;
    mem_pkg::lane_t r_hi;
    case (op)
      ctrl_pkg::ADD: begin
        r_lo = src1[15:0] + src2[15:0];
        r_hi = src1[31:16] + src2[31:16];
      end
      ctrl_pkg::SUB: begin
        r_lo = src1[15:0] - src2[15:0];
        r_hi = src1[31:16] - src2[31:16];
      end
      ctrl_pkg::XOR: begin
        r_lo = src1[15:0] ^ src2[15:0];
        r_hi = src1[31:16] ^ src2[31:16];
      end
      default: begin
        r_lo = src1[15:0];  // PASS
        r_hi = src1[31:16];
      end
    endcase
    return {r_hi, r_lo};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_ack(input string test, input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);  // Outputs settled here
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        fail_run($sformatf("%s: cmd_ack did not go to %b within %0d cycles",
                           test, level, ACK_TIMEOUT));
      end
    end while (cmd_ack !== level);
  endtask

  // Full four-phase cycle where hold keeps req high past the ack
  task automatic run_cmd(input string test, input ctrl_pkg::cmd_op_t op,
                         input ctrl_pkg::inst_t inst, input mem_pkg::word_t wdata,
                         input int hold, input mem_pkg::word_t exp_rsp);
    logic has_rsp;
    has_rsp = (op == ctrl_pkg::PEEK) || (op == ctrl_pkg::DUMP);
    @(posedge clk);
    cmd_op    <= op;
    cmd_inst  <= inst;
    cmd_wdata <= wdata;
    cmd_req   <= 1'b1;
    wait_ack(test, 1'b1);
    if (has_rsp) begin
      check_word(test, exp_rsp, rsp_data);  // Valid while ack is high
    end
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_ack(test, 1'b1, cmd_ack);
      if (has_rsp) begin
        check_word(test, exp_rsp, rsp_data);
      end
    end
    @(posedge clk);
    cmd_req <= 1'b0;
    wait_ack(test, 1'b0);
  endtask

  task automatic do_load(input string test, input mem_pkg::word_t data, input int hold);
    run_cmd(test, ctrl_pkg::LOAD, '0, data, hold, '0);
    ref_mem[ld_ptr_m] = data;
    ld_ptr_m++;
  endtask

  task automatic do_exec(input string test, input ctrl_pkg::alu_op_t op,
                         input mem_pkg::addr_t src1, input mem_pkg::addr_t src2,
                         input mem_pkg::addr_t dst, input int hold);
    run_cmd(test, ctrl_pkg::EXEC, {op, src2, src1, dst}, '0, hold, '0);
    ref_mem[dst] = lane_result(op, ref_mem[src1], ref_mem[src2]);
  endtask

  task automatic do_peek(input string test, input mem_pkg::addr_t addr, input int hold);
    run_cmd(test, ctrl_pkg::PEEK, {2'b00, 8'h00, addr, 8'h00}, '0, hold,
            ref_mem[addr]);  // src1 field
  endtask

  task automatic do_dump(input string test);
    run_cmd(test, ctrl_pkg::DUMP, '0, '0, 0, ref_mem[dump_ptr_m]);
    dump_ptr_m++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int             hold;
    mem_pkg::addr_t dst;
    cmd_req    = 1'b0;
    cmd_op     = ctrl_pkg::LOAD;
    cmd_inst   = '0;
    cmd_wdata  = '0;
    rst        = 1'b1;
    ld_ptr_m   = '0;
    dump_ptr_m = Y_BASE;
    void'($urandom(SEED));
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    check_ack("reset", 1'b0, cmd_ack);
    check_word("reset", '0, rsp_data);

    // Sequential loads then random readback
    for (int i = 0; i < N_LOAD; i++) do_load("load_peek", $urandom, 0);
    for (int i = 0; i < 24; i++) begin
      do_peek("load_peek", mem_pkg::addr_t'($urandom_range(N_LOAD - 1, 0)), 0);
    end

    // Every ALU op on random operands
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 4; i++) begin
        dst = mem_pkg::addr_t'($urandom_range(255, 64));
        do_exec("exec_ops", ctrl_pkg::alu_op_t'(k),
                mem_pkg::addr_t'($urandom_range(N_LOAD - 1, 0)),
                mem_pkg::addr_t'($urandom_range(N_LOAD - 1, 0)), dst, 0);
        do_peek("exec_ops", dst, 0);
      end
    end

    // Lane wrap on words loaded at 48 to 50
    do_load("exec_wrap", 32'h0001_ffff, 0);
    do_load("exec_wrap", 32'hffff_0001, 0);
    do_load("exec_wrap", 32'h0000_0000, 0);
    do_exec("exec_wrap", ctrl_pkg::ADD, 8'd48, 8'd49, 8'd200, 0);
    do_peek("exec_wrap", 8'd200, 0);
    do_exec("exec_wrap", ctrl_pkg::SUB, 8'd50, 8'd49, 8'd201, 0);
    do_peek("exec_wrap", 8'd201, 0);
    do_exec("exec_wrap", ctrl_pkg::ADD, 8'd49, 8'd49, 8'd202, 0);
    do_peek("exec_wrap", 8'd202, 0);

    // Fill the result region and stream it back
    for (int i = 0; i < 8; i++) begin
      do_exec("dump_region", ctrl_pkg::alu_op_t'($urandom_range(3, 0)),
              mem_pkg::addr_t'($urandom_range(N_LOAD - 1, 0)),
              mem_pkg::addr_t'($urandom_range(N_LOAD - 1, 0)), Y_BASE + i[7:0], 0);
    end
    for (int i = 0; i < 8; i++) do_dump("dump_region");

    // Back-pressure on each command kind
    hold = $urandom_range(8, 1);
    do_load("backpressure", $urandom, hold);
    do_peek("backpressure", ld_ptr_m - 8'd1, hold);
    do_load("backpressure", $urandom, 0);  // Must land right after the held load
    do_peek("backpressure", ld_ptr_m - 8'd2, 0);
    do_peek("backpressure", ld_ptr_m - 8'd1, 0);
    do_exec("backpressure", ctrl_pkg::XOR, 8'd3, 8'd7, 8'd150, $urandom_range(8, 1));
    do_peek("backpressure", 8'd150, 0);
    do_peek("backpressure", 8'd151, 0);

    if (UUT.u_assert.err_cnt == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      fail_run($sformatf("%0d assertion failures in the bound checker",
                         UUT.u_assert.err_cnt));
    end
  end

endmodule

`default_nettype wire
